// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    parameter int xlen      = 32;
    parameter int reg_idx_w = 5;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]      word_t;

    // Major opcodes of the supported classes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    typedef enum logic [5:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_lui, op_auipc,
        op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
    } op_kind_e;

    typedef struct packed {
        logic [xlen-reg_idx_w-1:0] pad;
        logic [reg_idx_w-1:0]      shamt;
    } shift_view_t;

    // Sign-extended immediate, or shamt for the immediate shifts
    typedef union packed {
        word_t       imm;
        shift_view_t shift;
    } imm_u;

endpackage

`default_nettype wire

// ==== exe_bus_pkg.sv ====
`default_nettype none

package exe_bus_pkg;

    import isa_pkg::*;

    // One decoded instruction waiting in the queue
    typedef struct packed {
        op_kind_e kind;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_u     imm;
        word_t    pc;
    } exe_op_t;

    // Retired instruction as seen on the result port
    typedef struct packed {
        logic     rd_en;
        reg_idx_t rd;
        word_t    rd_data;
        logic     jump_en;
        word_t    jump_addr;
        word_t    pc;
    } exe_res_t;

endpackage

`default_nettype wire

// ==== insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder
    import isa_pkg::*, exe_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  word_t   adr,
    input  word_t   dat_w,
    output logic    ack,
    output logic    err,
    input  logic    full,
    output logic    push,
    output exe_op_t op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       valid;
    logic       take;
    word_t      imm_i;

    assign opcode = dat_w[6:0];
    assign funct3 = dat_w[14:12];
    assign funct7 = dat_w[31:25];
    assign imm_i  = {{20{dat_w[31]}}, dat_w[31:20]};

    // Only one answer per strobe, the master drops stb after it
    assign take = cyc && stb && !ack && !err;
    assign push = take && we && valid && !full;

    always_comb begin
        valid  = 1'b1;
        op     = '0;
        op.rd  = dat_w[11:7];
        op.rs1 = dat_w[19:15];
        op.rs2 = dat_w[24:20];
        op.pc  = adr;
        case (opcode)
            opc_op: begin
                valid = funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000:  op.kind = funct7[5] ? op_sub : op_add;
                    3'b001:  op.kind = op_sll;
                    3'b010:  op.kind = op_slt;
                    3'b011:  op.kind = op_sltu;
                    3'b100:  op.kind = op_xor;
                    3'b101:  op.kind = funct7[5] ? op_sra : op_srl;
                    3'b110:  op.kind = op_or;
                    default: op.kind = op_and;
                endcase
            end
            opc_op_imm: begin
                case (funct3)
                    3'b001, 3'b101: begin
                        op.imm.shift.shamt = dat_w[24:20];
                        valid   = funct7 == 7'b0000000 || (funct3[2] && funct7 == 7'b0100000);
                        op.kind = !funct3[2] ? op_slli : (funct7[5] ? op_srai : op_srli);
                    end
                    default: begin
                        op.imm.imm = imm_i;
                        case (funct3)
                            3'b000:  op.kind = op_addi;
                            3'b010:  op.kind = op_slti;
                            3'b011:  op.kind = op_sltiu;
                            3'b100:  op.kind = op_xori;
                            3'b110:  op.kind = op_ori;
                            default: op.kind = op_andi;
                        endcase
                    end
                endcase
            end
            opc_lui: begin
                op.kind    = op_lui;
                op.imm.imm = {dat_w[31:12], 12'd0};
            end
            opc_auipc: begin
                op.kind    = op_auipc;
                op.imm.imm = {dat_w[31:12], 12'd0};
            end
            opc_jal: begin
                op.kind    = op_jal;
                op.imm.imm = {{11{dat_w[31]}}, dat_w[31], dat_w[19:12], dat_w[20],
                              dat_w[30:21], 1'b0};
            end
            opc_jalr: begin
                valid      = funct3 == 3'b000;
                op.kind    = op_jalr;
                op.imm.imm = imm_i;
            end
            opc_branch: begin
                valid      = funct3[2:1] != 2'b01;
                op.imm.imm = {{19{dat_w[31]}}, dat_w[31], dat_w[7], dat_w[30:25],
                              dat_w[11:8], 1'b0};
                case (funct3)
                    3'b000:  op.kind = op_beq;
                    3'b001:  op.kind = op_bne;
                    3'b100:  op.kind = op_blt;
                    3'b101:  op.kind = op_bge;
                    3'b110:  op.kind = op_bltu;
                    default: op.kind = op_bgeu;
                endcase
            end
            default: valid = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Wishbone answer
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= push;
            // Refusals never wait on the queue
            err <= take && (!we || !valid);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_) !(ack && err))
        else $error("ack and err together");

endmodule

`default_nettype wire

// ==== op_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_queue
    import exe_bus_pkg::*;
#(
    parameter int queue_depth = 2
) (
    input  logic    clk,
    input  logic    rst_,
    input  logic    push,
    input  exe_op_t wr_op,
    output logic    full,
    input  logic    pop,
    output exe_op_t rd_op,
    output logic    not_empty
);

    localparam int ptr_w = $clog2(queue_depth);

    exe_op_t          slots [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    assign full      = count == queue_depth[ptr_w:0];
    assign not_empty = count != '0;
    assign rd_op     = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= wr_op;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_) push |-> !full)
        else $error("push into a full queue");
    assert property (@(posedge clk) disable iff (!rst_) pop |-> not_empty)
        else $error("pop from an empty queue");

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [32];

    // x0 reads as zero whatever the array holds
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_) we |-> wr_idx != '0)
        else $error("write to x0");

endmodule

`default_nettype wire

// ==== exe_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_unit
    import isa_pkg::*, exe_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_,
    input  exe_op_t  head,
    input  logic     not_empty,
    output logic     pop,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     reg_we,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output exe_res_t res,
    output logic     res_valid,
    input  logic     res_ready
);

    word_t    imm;
    word_t    link;
    word_t    jalr_sum;
    word_t    rd_val;
    logic     taken;
    logic     is_branch;
    exe_res_t nxt;

    // Slot is free, or its result leaves this cycle
    assign pop = not_empty && (!res_valid || res_ready);

    assign rs1      = head.rs1;
    assign rs2      = head.rs2;
    assign imm      = head.imm.imm;
    assign link     = head.pc + 32'd4;
    assign jalr_sum = rs1_data + imm;
    assign is_branch = head.kind inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

    ////////////////////////////////////////////////////////////////////
    // ALU and branch compare
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_val = '0;
        taken  = 1'b0;
        case (head.kind)
            op_add:   rd_val = rs1_data + rs2_data;
            op_sub:   rd_val = rs1_data - rs2_data;
            op_sll:   rd_val = rs1_data << rs2_data[4:0];
            op_slt:   rd_val = word_t'($signed(rs1_data) < $signed(rs2_data));
            op_sltu:  rd_val = word_t'(rs1_data < rs2_data);
            op_xor:   rd_val = rs1_data ^ rs2_data;
            op_srl:   rd_val = rs1_data >> rs2_data[4:0];
            op_sra:   rd_val = $signed(rs1_data) >>> rs2_data[4:0];
            op_or:    rd_val = rs1_data | rs2_data;
            op_and:   rd_val = rs1_data & rs2_data;
            op_addi:  rd_val = rs1_data + imm;
            op_slti:  rd_val = word_t'($signed(rs1_data) < $signed(imm));
            op_sltiu: rd_val = word_t'(rs1_data < imm);
            op_xori:  rd_val = rs1_data ^ imm;
            op_ori:   rd_val = rs1_data | imm;
            op_andi:  rd_val = rs1_data & imm;
            op_slli:  rd_val = rs1_data << head.imm.shift.shamt;
            op_srli:  rd_val = rs1_data >> head.imm.shift.shamt;
            op_srai:  rd_val = $signed(rs1_data) >>> head.imm.shift.shamt;
            op_lui:   rd_val = imm;
            op_auipc: rd_val = head.pc + imm;
            op_jal, op_jalr: rd_val = link;
            op_beq:   taken = rs1_data == rs2_data;
            op_bne:   taken = rs1_data != rs2_data;
            op_blt:   taken = $signed(rs1_data) < $signed(rs2_data);
            op_bge:   taken = $signed(rs1_data) >= $signed(rs2_data);
            op_bltu:  taken = rs1_data < rs2_data;
            default:  taken = rs1_data >= rs2_data;
        endcase
    end

    always_comb begin
        nxt.rd_en   = !is_branch && head.rd != '0;
        nxt.rd      = head.rd;
        nxt.rd_data = rd_val;
        nxt.jump_en = is_branch || head.kind == op_jal || head.kind == op_jalr;
        nxt.pc      = head.pc;
        if (head.kind == op_jal || (is_branch && taken)) begin
            nxt.jump_addr = head.pc + imm;
        end else if (head.kind == op_jalr) begin
            nxt.jump_addr = {jalr_sum[31:1], 1'b0};
        end else if (is_branch) begin
            nxt.jump_addr = link;
        end else begin
            nxt.jump_addr = '0;
        end
    end

    // Writeback lands on the pop edge
    assign reg_we  = pop && nxt.rd_en;
    assign wr_idx  = head.rd;
    assign wr_data = rd_val;

    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            res       <= '0;
            res_valid <= 1'b0;
        end else if (pop) begin
            res       <= nxt;
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_)
                     res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("result changed before it was taken");

endmodule

`default_nettype wire

// ==== exe_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_core
    import isa_pkg::*, exe_bus_pkg::*;
#(
    parameter int queue_depth = 2
) (
    input  logic     clk,
    input  logic     rst_,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  word_t    adr,
    input  word_t    dat_w,
    output logic     ack,
    output logic     err,
    output exe_res_t res,
    output logic     res_valid,
    input  logic     res_ready
);

    logic     push;
    logic     full;
    logic     pop;
    logic     not_empty;
    exe_op_t  dec_op;
    exe_op_t  head;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     reg_we;
    reg_idx_t wr_idx;
    word_t    wr_data;

    insn_decoder u_dec (
        .clk, .rst_, .cyc, .stb, .we, .adr, .dat_w, .ack, .err,
        .full, .push, .op(dec_op)
    );

    op_queue #(.queue_depth(queue_depth)) u_queue (
        .clk, .rst_, .push, .wr_op(dec_op), .full,
        .pop, .rd_op(head), .not_empty
    );

    reg_file u_rf (
        .clk, .rst_, .rs1, .rs2, .rs1_data, .rs2_data,
        .we(reg_we), .wr_idx, .wr_data
    );

    exe_unit u_exe (
        .clk, .rst_, .head, .not_empty, .pop, .rs1, .rs2, .rs1_data, .rs2_data,
        .reg_we, .wr_idx, .wr_data, .res, .res_valid, .res_ready
    );

endmodule

`default_nettype wire

// ==== tb_exe_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_core
    import isa_pkg::*, exe_bus_pkg::*;
;

    localparam int queue_depth = 2;
    // Instructions issued over all tests
    localparam int n_insns = 114;

    logic     clk;
    logic     rst_;
    logic     cyc;
    logic     stb;
    logic     we;
    word_t    adr;
    word_t    dat_w;
    logic     ack;
    logic     err;
    exe_res_t res;
    logic     res_valid;
    logic     res_ready;

    word_t    model [32];
    exe_res_t exp_q [$];
    word_t    pc;
    string    test_name;
    logic     stall;
    int       ack_count;
    int       value_errors;
    int       other_errors;

    exe_core #(.queue_depth(queue_depth)) dut (
        .clk, .rst_, .cyc, .stb, .we, .adr, .dat_w, .ack, .err,
        .res, .res_valid, .res_ready
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(input logic [19:0] upper, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {upper, rd, opc};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic exe_res_t predict(input word_t at, input word_t insn);
        exe_res_t   r;
        word_t      a;
        word_t      b;
        word_t      val;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        logic [2:0] f3;
        logic       alt;
        logic       taken;
        r     = '0;
        a     = model[insn[19:15]];
        b     = model[insn[24:20]];
        f3    = insn[14:12];
        val   = '0;
        taken = 1'b0;
        imm_i = {{20{insn[31]}}, insn[31:20]};
        imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        r.pc  = at;
        r.rd  = insn[11:7];
        case (insn[6:0])
            opc_op, opc_op_imm: begin
                if (insn[6:0] == opc_op_imm) begin
                    b = (f3 == 3'b001 || f3 == 3'b101) ? {27'd0, insn[24:20]} : imm_i;
                end
                // Bit 30 means sub only with register operands
                alt = insn[30] && (insn[6:0] == opc_op || f3 == 3'b101);
                case (f3)
                    3'b000:  val = alt ? a - b : a + b;
                    3'b001:  val = a << b[4:0];
                    3'b010:  val = {31'd0, $signed(a) < $signed(b)};
                    3'b011:  val = {31'd0, a < b};
                    3'b100:  val = a ^ b;
                    3'b101: begin
                        val = a >> b[4:0];
                        if (alt) begin
                            val = $signed(a) >>> b[4:0];
                        end
                    end
                    3'b110:  val = a | b;
                    default: val = a & b;
                endcase
            end
            opc_lui:   val = {insn[31:12], 12'd0};
            opc_auipc: val = at + {insn[31:12], 12'd0};
            opc_jal: begin
                val         = at + 32'd4;
                r.jump_en   = 1'b1;
                r.jump_addr = at + imm_j;
            end
            opc_jalr: begin
                val         = at + 32'd4;
                r.jump_en   = 1'b1;
                r.jump_addr = (a + imm_i) & 32'hffff_fffe;
            end
            default: begin
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    default: taken = a >= b;
                endcase
                r.jump_en   = 1'b1;
                r.jump_addr = taken ? at + imm_b : at + 32'd4;
            end
        endcase
        r.rd_en   = insn[6:0] != opc_branch && r.rd != '0;
        r.rd_data = val;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Wishbone driver and result checks
    //////////////////////////////////////////////////////////////////////

    task automatic issue(input word_t insn, input logic wr,
                         output logic got_ack, output logic got_err);
        exe_res_t expd;
        int       waited;
        @(negedge clk);
        expd   = predict(pc, insn);
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = wr;
        adr    = pc;
        dat_w  = insn;
        waited = 0;
        while (!ack && !err && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        got_ack = ack;
        got_err = err;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        assert (ack || err) else begin
            other_errors++;
            $display("No Wishbone answer for instruction %h at pc %h", insn, pc);
        end
        if (ack) begin
            ack_count++;
            exp_q.push_back(expd);
            if (expd.rd_en) begin
                model[expd.rd] = expd.rd_data;
            end
        end
        pc = pc + 32'd4;
    endtask

    task automatic run(input word_t insn);
        logic got_ack;
        logic got_err;
        issue(insn, 1'b1, got_ack, got_err);
        assert (got_ack && !got_err) else begin
            other_errors++;
            $display("Instruction %h in test %s was not acknowledged", insn, test_name);
        end
    endtask

    task automatic refuse(input word_t insn, input logic wr, input string what);
        logic got_ack;
        logic got_err;
        issue(insn, wr, got_ack, got_err);
        assert (got_err && !got_ack) else begin
            other_errors++;
            $display("The %s instruction was not refused with err", what);
        end
    endtask

    // lui then addi, upper part rounded for the sign of the low part
    task automatic load_reg(input reg_idx_t r, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        run(enc_u(hi[31:12], r, opc_lui));
        run(enc_i(v[11:0], r, 3'b000, r, opc_op_imm));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("%0d results of test %s never came out", exp_q.size(), test_name);
        end
        exp_q.delete();
    endtask

    task automatic check_field(input string field, input word_t expv, input word_t actv);
        assert (actv === expv) else begin
            value_errors++;
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, field, expv, actv);
        end
    endtask

    // Drives res_ready and checks every accepted result in issue order
    initial begin : result_monitor
        exe_res_t want;
        res_ready = 1'b0;
        forever begin
            @(negedge clk);
            res_ready = !stall;
            if (res_valid && !stall) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("A result came out with no instruction waiting for it");
                end else begin
                    want = exp_q.pop_front();
                    check_field("pc", want.pc, res.pc);
                    check_field("rd_en", word_t'(want.rd_en), word_t'(res.rd_en));
                    if (want.rd_en) begin
                        check_field("rd", word_t'(want.rd), word_t'(res.rd));
                        check_field("rd_data", want.rd_data, res.rd_data);
                    end
                    check_field("jump_en", word_t'(want.jump_en), word_t'(res.jump_en));
                    check_field("jump_addr", want.jump_addr, res.jump_addr);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic alu_test();
        word_t v1;
        word_t v2;
        test_name = "alu";
        for (int round = 0; round < 3; round++) begin
            v1 = $urandom;
            v2 = $urandom;
            // Mixed signs for slt and negative values for sra
            if (round == 0) begin
                v1[31] = 1'b1;
                v2[31] = 1'b0;
            end else if (round == 1) begin
                v1[31] = 1'b0;
                v2[31] = 1'b1;
            end
            load_reg(5'd1, v1);
            load_reg(5'd2, v2);
            for (int f = 0; f < 8; f++) begin
                run(enc_r(7'd0, 5'd2, 5'd1, 3'(f), reg_idx_t'(10 + f)));
            end
            run(enc_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd18));
            run(enc_r(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd19));
            for (int f = 0; f < 8; f++) begin
                if (f == 1 || f == 5) begin
                    run(enc_i({7'd0, 5'($urandom)}, 5'd1, 3'(f), reg_idx_t'(20 + f),
                              opc_op_imm));
                end else begin
                    run(enc_i(12'($urandom), 5'd1, 3'(f), reg_idx_t'(20 + f), opc_op_imm));
                end
            end
            run(enc_i({7'b0100000, 5'($urandom)}, 5'd1, 3'b101, 5'd28, opc_op_imm));
        end
        drain();
    endtask

    task automatic upper_test();
        test_name = "lui_auipc";
        run(enc_u(20'($urandom), 5'd6, opc_lui));
        run(enc_u(20'($urandom), 5'd7, opc_auipc));
        run(enc_u(20'hfffff, 5'd6, opc_lui));
        run(enc_u(20'h80000, 5'd7, opc_auipc));
        drain();
    endtask

    task automatic jump_test();
        test_name = "jal_jalr";
        load_reg(5'd3, $urandom | 32'd1);
        run(enc_j({8'($urandom), 12'($urandom), 1'b0}, 5'd1));
        run(enc_j(21'h1ffff0, 5'd0));
        run(enc_i(12'($urandom), 5'd3, 3'b000, 5'd5, opc_jalr));
        // Odd base plus even offset leaves bit 0 to clear
        run(enc_i(12'h7fe, 5'd3, 3'b000, 5'd4, opc_jalr));
        drain();
    endtask

    task automatic branch_test();
        logic [2:0] kinds [6];
        word_t      neg;
        test_name = "branch";
        kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        neg = $urandom | 32'h8000_0000;
        load_reg(5'd8, neg);
        load_reg(5'd9, $urandom & 32'h7fff_ffff);
        load_reg(5'd10, neg);
        // Pairs below, above and equal give both outcomes for each kind
        for (int k = 0; k < 6; k++) begin
            run(enc_b({12'($urandom), 1'b0}, 5'd9, 5'd8, kinds[k]));
            run(enc_b({12'($urandom), 1'b0}, 5'd8, 5'd9, kinds[k]));
            run(enc_b({12'($urandom), 1'b0}, 5'd10, 5'd8, kinds[k]));
        end
        drain();
    endtask

    task automatic backpressure_test();
        int acks_before;
        test_name = "backpressure";
        @(posedge clk);
        stall = 1'b1;
        run(enc_i(12'($urandom), 5'd0, 3'b000, 5'd5, opc_op_imm));
        for (int i = 0; i < queue_depth; i++) begin
            run(enc_i(12'($urandom), 5'd5, 3'b000, 5'd5, opc_op_imm));
        end
        acks_before = ack_count;
        fork
            begin
                run(enc_i(12'($urandom), 5'd5, 3'b000, 5'd5, opc_op_imm));
                run(enc_r(7'd0, 5'd5, 5'd5, 3'b000, 5'd6));
                run(enc_i(12'($urandom), 5'd6, 3'b000, 5'd7, opc_op_imm));
            end
            begin
                repeat (10) @(posedge clk);
                assert (ack_count == acks_before && cyc) else begin
                    other_errors++;
                    $display("An instruction was acknowledged while results were stalled");
                end
                stall = 1'b0;
            end
        join
        drain();
    endtask

    task automatic refused_test();
        test_name = "refused";
        refuse(enc_i(12'h010, 5'd1, 3'b010, 5'd11, 7'b0000011), 1'b1, "load");
        refuse(enc_i(12'h020, 5'd1, 3'b010, 5'd12, 7'b0100011), 1'b1, "store");
        refuse(enc_i(12'h300, 5'd1, 3'b001, 5'd12, 7'b1110011), 1'b1, "csr");
        refuse(enc_i(12'h001, 5'd1, 3'b000, 5'd11, opc_op_imm), 1'b0, "read cycle");
        run(enc_r(7'd0, 5'd12, 5'd11, 3'b000, 5'd13));
        drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(29388));
        rst_         = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        stall        = 1'b0;
        pc           = 32'h0000_1000;
        ack_count    = 0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_ = 1'b1;
        alu_test();
        upper_test();
        jump_test();
        branch_test();
        backpressure_test();
        refused_test();
        repeat (5) @(negedge clk);
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (n_insns * 20 + 500) @(posedge clk);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
isa_pkg.sv
exe_bus_pkg.sv
insn_decoder.sv
op_queue.sv
reg_file.sv
exe_unit.sv
exe_core.sv
tb_exe_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_exe_core
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
